// ==== vlog.f ====
verilog/wb_bus_pkg.sv
verilog/dma_xfer_pkg.sv
verilog/mm2s_request.sv
verilog/mm2s_return.sv
verilog/mm2s_stream.sv
verilog/mm2s_top.sv
tb/tb_wb_mem.sv
tb/tb_mm2s.sv

// ==== Bender.yml ====
package:
  name: mm2s_dma

sources:
  # Packages first, then the reader stages and the top level
  - files:
      - verilog/wb_bus_pkg.sv
      - verilog/dma_xfer_pkg.sv
      - verilog/mm2s_request.sv
      - verilog/mm2s_return.sv
      - verilog/mm2s_stream.sv
      - verilog/mm2s_top.sv
  # Testbench, top module tb_mm2s
  - target: test
    files:
      - tb/tb_wb_mem.sv
      - tb/tb_mm2s.sv

// ==== tb/tb_mm2s.sv ====
// Testbench for the memory-to-stream DMA reader.
// Transfers are picked by a Galois LFSR (seed 95) and run against the
// Wishbone memory model with random stall and ack delay. The stream
// bytes are checked against a byte model of each transfer. Directed
// sweeps cover every size and lane, and bus errors are injected too.

`timescale 1ns/1ps

module tb_mm2s;
	import dma_xfer_pkg::*;

	logic clk;
	logic reset;
	logic request;
	logic inc;
	xfer_size_e size;
	logic [10:0] xfer_len;
	logic [23:0] addr;
	logic busy;
	logic err;
	logic rd_cyc;
	logic rd_stb;
	logic [21:0] rd_addr;
	logic [3:0] rd_sel;
	logic rd_stall;
	logic rd_ack;
	logic [31:0] rd_data;
	logic rd_err;
	logic m_valid;
	logic [31:0] m_data;
	logic [2:0] m_bytes;
	logic m_last;
	// Memory model controls
	logic stall_req;
	logic hold_req;
	logic err_req;
	int bad_sel;

	logic [15:0] lfsr_state;
	int tests_run;
	int tests_failed;
	int check_errors;
	logic hung;

	always #5 clk = ~clk;

	mm2s_top #(
		.ADDRESS_WIDTH(24),
		.LGLENGTH(10)
	) mm2s_top_inst (
		.i_clk(clk), .i_reset(reset),
		.i_request(request), .o_busy(busy), .o_err(err),
		.i_inc(inc), .i_size(size), .i_transferlen(xfer_len), .i_addr(addr),
		.o_rd_cyc(rd_cyc), .o_rd_stb(rd_stb), .o_rd_addr(rd_addr), .o_rd_sel(rd_sel),
		.i_rd_stall(rd_stall), .i_rd_ack(rd_ack), .i_rd_data(rd_data), .i_rd_err(rd_err),
		.M_VALID(m_valid), .M_DATA(m_data), .M_BYTES(m_bytes), .M_LAST(m_last)
	);

	tb_wb_mem mem_inst (
		.i_clk(clk), .i_reset(reset),
		.i_cyc(rd_cyc), .i_stb(rd_stb), .i_addr(rd_addr), .i_sel(rd_sel), .i_size(size),
		.i_stall_req(stall_req), .i_hold_req(hold_req), .i_err_req(err_req),
		.o_stall(rd_stall), .o_ack(rd_ack), .o_data(rd_data), .o_err(rd_err),
		.o_bad_sel(bad_sel)
	);

	////////////////////////////////////////
	// Random numbers and memory contents
	////////////////////////////////////////

	function automatic logic [15:0] galois_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = galois_step(lfsr_state);
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	function automatic logic [7:0] mem_byte(input int a);
		return 8'(a * 7 + 3);
	endfunction

	////////////////////////////////////////
	// Transfer tasks
	////////////////////////////////////////

	// Present the settings and hold the request until busy rises
	task automatic launch(input logic t_inc, input logic [1:0] t_size,
			input logic [23:0] t_addr, input int t_len, output logic ok);
		int wait_n;
		inc = t_inc;
		size = xfer_size_e'(t_size);
		addr = t_addr;
		xfer_len = 11'(t_len);
		request = 1'b1;
		wait_n = 0;
		while (!busy && wait_n < 20)
		begin
			@(negedge clk);
			wait_n++;
		end
		request = 1'b0;
		ok = busy;
		if (!ok)
			$display("Timeout: DUT did not go busy after a request");
	endtask

	task automatic transfer_and_check(input string name, input logic t_inc,
			input logic [1:0] t_size, input logic [23:0] t_addr, input int t_len);
		logic [7:0] expect_q[$];
		logic [7:0] got_q[$];
		int unit;
		int base;
		int pos;
		int left;
		int n;
		int fails;
		int wait_n;
		int sel_before;
		logic ok;
		logic done;
		fails = 0;
		sel_before = bad_sel;
		// Byte model of the transfer
		if (t_inc)
		begin
			for (int i = 0; i < t_len; i++)
				expect_q.push_back(mem_byte(int'(t_addr) + i));
		end
		else
		begin
			unit = (t_size == 2'd3) ? 1 : (t_size == 2'd2) ? 2 : 4;
			base = int'(t_addr) & ~(unit - 1);
			pos = int'(t_addr);
			left = t_len;
			// First chunk runs to the unit end and later ones repeat the unit
			while (left > 0)
			begin
				n = base + unit - pos;
				if (n > left)
					n = left;
				for (int i = 0; i < n; i++)
					expect_q.push_back(mem_byte(pos + i));
				left -= n;
				pos = base;
			end
		end
		launch(t_inc, t_size, t_addr, t_len, ok);
		done = 1'b0;
		wait_n = 0;
		while (ok && !done && wait_n < 2000)
		begin
			stall_req = (rand_bits(2) == 0);
			hold_req = (rand_bits(2) == 0);
			@(negedge clk);
			wait_n++;
			if (m_valid)
			begin
				if (m_bytes == 3'd0 || m_bytes > 3'd4)
				begin
					$display("CHECK FAILED %s: beat bytes expected 1 to 4 actual %0d",
						name, m_bytes);
					fails++;
				end
				else
				begin
					for (int k = 0; k < int'(m_bytes); k++)
						got_q.push_back(m_data[31 - 8 * k -: 8]);
				end
				done = m_last;
			end
		end
		stall_req = 1'b0;
		hold_req = 1'b0;
		if (!done)
		begin
			if (ok)
				$display("Timeout: %s never produced a last beat", name);
			hung = 1'b1;
			fails++;
		end
		else
		begin
			// Cycle after the last beat
			@(negedge clk);
			if (busy)
			begin
				$display("CHECK FAILED %s: busy after last beat expected 0 actual 1", name);
				fails++;
			end
			if (m_valid)
			begin
				$display("A beat followed the last beat in %s", name);
				fails++;
			end
			if (got_q.size() != expect_q.size())
			begin
				$display("CHECK FAILED %s: byte count expected %0d actual %0d",
					name, expect_q.size(), got_q.size());
				fails++;
			end
			else
			begin
				for (int i = 0; i < got_q.size(); i++)
				begin
					if (got_q[i] != expect_q[i])
					begin
						$display("CHECK FAILED %s: byte %0d expected %h actual %h",
							name, i, expect_q[i], got_q[i]);
						fails++;
						break;
					end
				end
			end
		end
		if (bad_sel != sel_before)
		begin
			$display("CHECK FAILED %s: bad selects expected 0 actual %0d",
				name, bad_sel - sel_before);
			fails++;
		end
		tests_run++;
		if (fails != 0)
			tests_failed++;
		check_errors += fails;
		$display("%-16s %-6s addr %h len %0d size %0d inc %0d",
			name, (fails == 0) ? "ok" : "FAILED", t_addr, t_len, t_size, t_inc);
	endtask

	// Acks held back so the cycle is still open when the error hits
	task automatic bus_error_test(input string name);
		int wait_n;
		int fails;
		int delay;
		int sel_before;
		logic ok;
		fails = 0;
		sel_before = bad_sel;
		stall_req = 1'b0;
		hold_req = 1'b1;
		launch(rand_bits(1), 2'(rand_bits(2)), 24'(rand_bits(12)),
			int'(rand_bits(6)) + 1, ok);
		delay = int'(rand_bits(2));
		for (int i = 0; i < delay; i++)
		begin
			stall_req = rand_bits(1);
			@(negedge clk);
		end
		err_req = 1'b1;
		@(negedge clk);
		err_req = 1'b0;
		// A read answers just as the cycle aborts
		hold_req = 1'b0;
		stall_req = 1'b0;
		wait_n = 0;
		while (!err && wait_n < 10)
		begin
			@(negedge clk);
			wait_n++;
		end
		if (!ok || !err)
		begin
			$display("Timeout: o_err never rose after the injected bus error");
			hung = 1'b1;
			fails++;
		end
		else
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (!err || busy || rd_cyc)
				begin
					$display("CHECK FAILED %s: err/busy/cyc expected 100 actual %b%b%b",
						name, err, busy, rd_cyc);
					fails++;
				end
				if (m_valid && m_last)
				begin
					$display("M_LAST seen after the bus error in %s", name);
					fails++;
				end
				@(negedge clk);
			end
		end
		if (bad_sel != sel_before)
		begin
			$display("CHECK FAILED %s: bad selects expected 0 actual %0d",
				name, bad_sel - sel_before);
			fails++;
		end
		stall_req = 1'b0;
		hold_req = 1'b0;
		tests_run++;
		if (fails != 0)
			tests_failed++;
		check_errors += fails;
		$display("%-16s %-6s", name, (fails == 0) ? "ok" : "FAILED");
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		request = 1'b0;
		inc = 1'b0;
		size = XS_WORD;
		xfer_len = '0;
		addr = '0;
		stall_req = 1'b0;
		hold_req = 1'b0;
		err_req = 1'b0;
		lfsr_state = 16'd95;
		tests_run = 0;
		tests_failed = 0;
		check_errors = 0;
		hung = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		// Idle state straight after reset
		tests_run++;
		if (busy || err || rd_cyc || rd_stb || m_valid)
		begin
			// Busy, err, cyc, stb and valid in that order
			$display("CHECK FAILED reset: expected 00000 actual %b%b%b%b%b",
				busy, err, rd_cyc, rd_stb, m_valid);
			check_errors++;
			tests_failed++;
		end
		$display("%-16s %-6s", "reset", (check_errors == 0) ? "ok" : "FAILED");
		// Every size code and start lane in both address modes
		for (int s = 0; s < 4; s++)
			for (int lane = 0; lane < 4; lane++)
				for (int m = 0; m < 2; m++)
					if (!hung)
						transfer_and_check($sformatf("dir_s%0d_l%0d_%s", s, lane,
							(m != 0) ? "inc" : "fix"), m[0], 2'(s),
							24'((rand_bits(10) << 2) | lane), int'(rand_bits(6)) + 1);
		// Random mix with an occasional error and a clean transfer after it
		for (int t = 0; t < 40; t++)
		begin
			if (!hung && t % 10 == 5)
				bus_error_test($sformatf("err_%0d", t));
			if (!hung)
				transfer_and_check($sformatf("rand_%0d", t), rand_bits(1),
					2'(rand_bits(2)), 24'(rand_bits(12)), int'(rand_bits(6)) + 1);
		end
		$display("Tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, check_errors);
		if (check_errors == 0 && !hung)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== tb/tb_wb_mem.sv ====
// Read-only Wishbone memory model for the DMA reader testbench.
// Byte a holds the low 8 bits of a*7+3, lane 0 in the MSB of a word.
// Stall, ack hold-off and error come from the testbench top. Every
// accepted strobe has its select mask checked against the transfer size.

`timescale 1ns/1ps

module tb_wb_mem (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_cyc,
	input  logic i_stb,
	input  logic [21:0] i_addr,
	input  logic [3:0] i_sel,
	input  logic [1:0] i_size,
	input  logic i_stall_req,
	input  logic i_hold_req,
	input  logic i_err_req,
	output logic o_stall,
	output logic o_ack,
	output logic [31:0] o_data,
	output logic o_err,
	output int o_bad_sel
);
	// Word addresses of reads in flight, oldest first
	logic [21:0] pending[$];
	int max_sel;

	function automatic logic [7:0] byte_at(input logic [23:0] a);
		return 8'(a * 7 + 3);
	endfunction

	function automatic logic [31:0] word_at(input logic [21:0] w);
		return {byte_at({w, 2'd0}), byte_at({w, 2'd1}), byte_at({w, 2'd2}),
			byte_at({w, 2'd3})};
	endfunction

	assign o_stall = i_stall_req;

	initial
	begin
		o_ack = 1'b0;
		o_err = 1'b0;
		o_data = '0;
		o_bad_sel = 0;
	end

	always @(posedge i_clk)
	begin
		o_ack <= 1'b0;
		o_err <= i_cyc && i_err_req && !i_reset;
		if (i_reset)
		begin
			pending.delete();
			o_bad_sel <= 0;
		end
		else if (!i_cyc)
			pending.delete();
		else
		begin
			// Oldest read answers unless held back this cycle
			if (pending.size() != 0 && !i_hold_req)
			begin
				o_ack <= 1'b1;
				o_data <= word_at(pending.pop_front());
			end
			if (i_stb && !i_stall_req)
			begin
				// Byte size needs one lane, halfword two at most
				max_sel = (i_size == 2'd3) ? 1 : (i_size == 2'd2) ? 2 : 4;
				if (i_sel == 4'd0 || $countones(i_sel) > max_sel)
				begin
					$display("Bad select mask %b for size code %0d at word %h",
						i_sel, i_size, i_addr);
					o_bad_sel <= o_bad_sel + 1;
				end
				pending.push_back(i_addr);
			end
		end
	end

endmodule

// ==== verilog/mm2s_top.sv ====
// Top level of the memory-to-stream DMA reader.
// Connects the request side, the acknowledge side and the stream packer
// to the configuration port, the 32-bit Wishbone read port and the
// outgoing byte stream. Parameters set here are passed to every stage.

`timescale 1ns/1ps

module mm2s_top #(
	parameter int ADDRESS_WIDTH = 24,
	parameter int LGLENGTH = 10
) (
	input  logic i_clk,
	input  logic i_reset,
	// Configuration
	input  logic i_request,
	output logic o_busy,
	output logic o_err,
	input  logic i_inc,
	input  dma_xfer_pkg::xfer_size_e i_size,
	input  logic [LGLENGTH:0] i_transferlen,
	input  logic [ADDRESS_WIDTH-1:0] i_addr,
	// Wishbone read master
	output logic o_rd_cyc,
	output logic o_rd_stb,
	output logic [ADDRESS_WIDTH-wb_bus_pkg::BUS_LSB-1:0] o_rd_addr,
	output wb_bus_pkg::bus_sel_t o_rd_sel,
	input  logic i_rd_stall,
	input  logic i_rd_ack,
	input  wb_bus_pkg::bus_data_t i_rd_data,
	input  logic i_rd_err,
	// Outgoing stream, always accepted
	output logic M_VALID,
	output wb_bus_pkg::bus_data_t M_DATA,
	output dma_xfer_pkg::beat_bytes_t M_BYTES,
	output logic M_LAST
);
	import wb_bus_pkg::*;
	import dma_xfer_pkg::*;

	logic start;
	logic done;
	logic inc_r;
	xfer_size_e size_r;
	beat_bytes_t first_bytes;
	beat_bytes_t ack_bytes;
	byte_lane_t ack_shift;
	logic len_done;
	logic last_ack;

	mm2s_request #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.LGLENGTH(LGLENGTH)
	) request_inst (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_request(i_request), .i_inc(i_inc), .i_size(i_size),
		.i_transferlen(i_transferlen), .i_addr(i_addr),
		.i_rd_stall(i_rd_stall), .i_rd_ack(i_rd_ack), .i_rd_err(i_rd_err),
		.i_done(done),
		.o_start(start), .o_busy(o_busy), .o_err(o_err),
		.o_inc(inc_r), .o_size(size_r), .o_first_bytes(first_bytes),
		.o_rd_cyc(o_rd_cyc), .o_rd_stb(o_rd_stb),
		.o_rd_addr(o_rd_addr), .o_rd_sel(o_rd_sel)
	);

	// Runs on the captured settings once busy
	mm2s_return #(
		.LGLENGTH(LGLENGTH)
	) return_inst (
		.i_clk(i_clk), .i_start(start), .i_busy(o_busy),
		.i_inc(inc_r), .i_size(size_r),
		.i_addr_lane(i_addr[BUS_LSB-1:0]), .i_transferlen(i_transferlen),
		.i_first_bytes(first_bytes), .i_rd_ack(i_rd_ack),
		.o_ack_bytes(ack_bytes), .o_ack_shift(ack_shift),
		.o_len_done(len_done), .o_last_ack(last_ack)
	);

	// Needs the raw settings in the start cycle
	mm2s_stream #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.LGLENGTH(LGLENGTH)
	) stream_inst (
		.i_clk(i_clk), .i_start(start), .i_busy(o_busy),
		.i_inc(i_inc), .i_size(i_size), .i_addr(i_addr),
		.i_transferlen(i_transferlen),
		.i_rd_cyc(o_rd_cyc), .i_rd_ack(i_rd_ack), .i_rd_data(i_rd_data),
		.i_ack_bytes(ack_bytes), .i_ack_shift(ack_shift),
		.i_len_done(len_done), .i_last_ack(last_ack),
		.o_done(done),
		.M_VALID(M_VALID), .M_DATA(M_DATA), .M_BYTES(M_BYTES), .M_LAST(M_LAST)
	);

endmodule

// ==== verilog/mm2s_stream.sv ====
// Stream packer of the DMA reader.
// Each returned word is shifted so that its first valid byte sits in
// the top lane, and goes out one cycle later as a beat with its byte
// count. Bytes left over once the length is covered go out in one
// flush beat. A beat with M_LAST raises o_done. No back-pressure.

`timescale 1ns/1ps

module mm2s_stream #(
	parameter int ADDRESS_WIDTH = 24,
	parameter int LGLENGTH = 10
) (
	input  logic i_clk,
	input  logic i_start,
	input  logic i_busy,
	// Configuration, stable while busy
	input  logic i_inc,
	input  dma_xfer_pkg::xfer_size_e i_size,
	input  logic [ADDRESS_WIDTH-1:0] i_addr,
	input  logic [LGLENGTH:0] i_transferlen,
	// Returned data
	input  logic i_rd_cyc,
	input  logic i_rd_ack,
	input  wb_bus_pkg::bus_data_t i_rd_data,
	// From the acknowledge side
	input  dma_xfer_pkg::beat_bytes_t i_ack_bytes,
	input  wb_bus_pkg::byte_lane_t i_ack_shift,
	input  logic i_len_done,
	input  logic i_last_ack,
	output logic o_done,
	output logic M_VALID,
	output wb_bus_pkg::bus_data_t M_DATA,
	output dma_xfer_pkg::beat_bytes_t M_BYTES,
	output logic M_LAST
);
	import wb_bus_pkg::*;
	import dma_xfer_pkg::*;

	logic ack;
	fill_t fill;
	fill_t next_fill;
	beat_bytes_t out_bytes;
	logic [ADDRESS_WIDTH-1:0] last_addr;
	logic first_last;

	assign ack = i_rd_cyc && i_rd_ack;

	// Drain the beat on the port, add the word arriving now
	assign next_fill = fill - (M_VALID ? M_BYTES : 3'd0) + (ack ? i_ack_bytes : 3'd0);
	assign out_bytes = (next_fill > fill_t'(BUS_BYTES)) ? beat_bytes_t'(BUS_BYTES)
		: next_fill;

	////////////////////////////////////////
	// Preliminary last flag
	////////////////////////////////////////

	// Address of the final byte; a fixed address never leaves its unit
	assign last_addr = i_inc ? i_addr + {{(ADDRESS_WIDTH-LGLENGTH-1){1'b0}}, i_transferlen}
		- 1'b1 : i_addr;

	always_comb
	begin
		case (i_size)
		XS_BYTE: first_last = (last_addr == i_addr);
		XS_HALF: first_last = (last_addr[ADDRESS_WIDTH-1:1] == i_addr[ADDRESS_WIDTH-1:1]);
		default: first_last = (last_addr[ADDRESS_WIDTH-1:BUS_LSB]
			== i_addr[ADDRESS_WIDTH-1:BUS_LSB]);
		endcase
	end

	////////////////////////////////////////
	// Beat control
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_start)
		begin
			fill <= '0;
			M_VALID <= 1'b0;
			M_BYTES <= '0;
			M_LAST <= first_last;
		end
		else if (!i_busy)
		begin
			fill <= '0;
			M_VALID <= 1'b0;
			M_BYTES <= '0;
			M_LAST <= 1'b0;
		end
		else
		begin
			fill <= next_fill;
			M_VALID <= 1'b0;
			if (ack)
			begin
				M_VALID <= 1'b1;
				M_BYTES <= out_bytes;
				M_LAST <= i_last_ack && (next_fill <= fill_t'(BUS_BYTES));
			end
			else if (i_len_done && next_fill != '0)
			begin
				// Flush what is left after the current beat
				M_VALID <= 1'b1;
				M_BYTES <= out_bytes;
				M_LAST <= (next_fill <= fill_t'(BUS_BYTES));
			end
		end
	end

	// First valid byte moved up to lane 0
	always_ff @(posedge i_clk)
	begin
		if (ack)
			M_DATA <= i_rd_data << {i_ack_shift, 3'b000};
	end

	assign o_done = M_VALID && M_LAST;

	// Never an empty or oversized beat
	a_beat_bytes: assert property (@(posedge i_clk)
		M_VALID |-> (M_BYTES != '0 && M_BYTES <= beat_bytes_t'(BUS_BYTES)));

endmodule

// ==== verilog/mm2s_return.sv ====
// Acknowledge side of the DMA reader.
// Follows the reads as they come back, in order. For the next returned
// word it tells the packer how many bytes are valid and which lane the
// first of them sits in, and flags when the final bytes arrive.
// Loads from the configuration on a start, clears while idle.

`timescale 1ns/1ps

module mm2s_return #(
	parameter int LGLENGTH = 10
) (
	input  logic i_clk,
	input  logic i_start,
	input  logic i_busy,
	// Captured settings
	input  logic i_inc,
	input  dma_xfer_pkg::xfer_size_e i_size,
	// Start values, sampled on i_start
	input  wb_bus_pkg::byte_lane_t i_addr_lane,
	input  logic [LGLENGTH:0] i_transferlen,
	input  dma_xfer_pkg::beat_bytes_t i_first_bytes,
	input  logic i_rd_ack,
	output dma_xfer_pkg::beat_bytes_t o_ack_bytes,
	output wb_bus_pkg::byte_lane_t o_ack_shift,
	output logic o_len_done,
	output logic o_last_ack
);
	import wb_bus_pkg::*;
	import dma_xfer_pkg::*;

	localparam logic [LGLENGTH:0] WORD_LEN = (LGLENGTH+1)'(BUS_BYTES);

	logic [LGLENGTH:0] ack_len;
	logic [LGLENGTH:0] ack_size_ext;
	logic [LGLENGTH:0] ack_rem;
	beat_bytes_t ack_size;
	beat_bytes_t rem_cap;
	byte_lane_t ack_lane;
	byte_lane_t next_lane;

	// Bytes still expected after the current acknowledge
	assign ack_size_ext = {{(LGLENGTH-2){1'b0}}, ack_size};
	assign ack_rem = ack_len - ack_size_ext;
	assign rem_cap = (ack_rem > WORD_LEN) ? 3'(BUS_BYTES) : ack_rem[2:0];

	always_comb
	begin
		// Walk forward through the word
		if (i_inc)
			next_lane = ack_lane + ack_size[BUS_LSB-1:0];
		else
		begin
			// Back to the start of the same unit
			case (i_size)
			XS_BYTE: next_lane = ack_lane;
			XS_HALF: next_lane = {ack_lane[1], 1'b0};
			default: next_lane = '0;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_start)
		begin
			ack_len <= i_transferlen;
			ack_size <= i_first_bytes;
			ack_lane <= i_addr_lane;
		end
		else if (!i_busy)
		begin
			ack_len <= '0;
			ack_size <= '0;
			ack_lane <= '0;
		end
		else if (i_rd_ack)
		begin
			ack_len <= o_last_ack ? '0 : ack_rem;
			// Later chunks start aligned, so lane 0 gives a full unit
			ack_size <= first_chunk_bytes(i_size, byte_lane_t'(0), rem_cap);
			ack_lane <= next_lane;
		end
	end

	assign o_ack_bytes = ack_size;
	assign o_ack_shift = ack_lane;
	assign o_len_done = (ack_len == '0);
	assign o_last_ack = (ack_len <= ack_size_ext);

endmodule

// ==== verilog/mm2s_request.sv ====
// Request side of the memory-to-stream DMA reader.
// A start captures the settings and opens a Wishbone cycle. Reads are
// pipelined, one per unstalled strobe, until every byte has been asked
// for. Reads in flight are counted so the cycle can close once the last
// one returns. A bus error closes the cycle at once and sets o_err,
// which holds until the next start.

`timescale 1ns/1ps

module mm2s_request #(
	parameter int ADDRESS_WIDTH = 24,
	parameter int LGLENGTH = 10
) (
	input  logic i_clk,
	input  logic i_reset,
	// Configuration, stable while busy
	input  logic i_request,
	input  logic i_inc,
	input  dma_xfer_pkg::xfer_size_e i_size,
	input  logic [LGLENGTH:0] i_transferlen,
	input  logic [ADDRESS_WIDTH-1:0] i_addr,
	// Bus responses
	input  logic i_rd_stall,
	input  logic i_rd_ack,
	input  logic i_rd_err,
	// Last beat has left the packer
	input  logic i_done,
	output logic o_start,
	output logic o_busy,
	output logic o_err,
	output logic o_inc,
	output dma_xfer_pkg::xfer_size_e o_size,
	output dma_xfer_pkg::beat_bytes_t o_first_bytes,
	// Wishbone read master
	output logic o_rd_cyc,
	output logic o_rd_stb,
	output logic [ADDRESS_WIDTH-wb_bus_pkg::BUS_LSB-1:0] o_rd_addr,
	output wb_bus_pkg::bus_sel_t o_rd_sel
);
	import wb_bus_pkg::*;
	import dma_xfer_pkg::*;

	// One full word as a length
	localparam logic [LGLENGTH:0] WORD_LEN = (LGLENGTH+1)'(BUS_BYTES);

	logic [ADDRESS_WIDTH-1:0] r_addr;
	logic [LGLENGTH:0] stb_len;
	logic [LGLENGTH:0] stb_size_ext;
	logic [LGLENGTH:0] stb_rem;
	logic [LGLENGTH:0] outstanding;
	beat_bytes_t stb_size;
	beat_bytes_t len_cap;
	beat_bytes_t rem_cap;
	beat_bytes_t next_size;
	bus_sel_t base_sel;
	bus_sel_t first_sel;
	bus_sel_t next_sel;
	logic taken;

	// Strobe accepted by the slave this cycle
	assign taken = o_rd_stb && !i_rd_stall;
	assign o_start = i_request && !o_busy;
	assign o_rd_addr = r_addr[ADDRESS_WIDTH-1:BUS_LSB];

	////////////////////////////////////////
	// First access
	////////////////////////////////////////

	assign len_cap = (i_transferlen > WORD_LEN) ? 3'(BUS_BYTES) : i_transferlen[2:0];
	assign o_first_bytes = first_chunk_bytes(i_size, i_addr[BUS_LSB-1:0], len_cap);
	// Aligned unit, trimmed to the lanes at or after the start lane
	assign first_sel = unit_sel(i_size, i_addr[BUS_LSB-1:0])
		& ({BUS_BYTES{1'b1}} >> i_addr[BUS_LSB-1:0]);

	////////////////////////////////////////
	// Next access
	////////////////////////////////////////

	assign stb_size_ext = {{(LGLENGTH-2){1'b0}}, stb_size};
	assign stb_rem = stb_len - stb_size_ext;
	assign rem_cap = (stb_rem > WORD_LEN) ? 3'(BUS_BYTES) : stb_rem[2:0];
	// Later chunks always begin on a unit boundary
	assign next_size = first_chunk_bytes(o_size, byte_lane_t'(0), rem_cap);

	always_comb
	begin
		// Step the aligned unit one unit further down the word
		case (o_size)
		XS_BYTE: next_sel = {base_sel[0], base_sel[3:1]};
		XS_HALF: next_sel = {base_sel[1:0], base_sel[3:2]};
		default: next_sel = {BUS_BYTES{1'b1}};
		endcase
		// Fixed address keeps hitting the same unit
		if (!o_inc)
			next_sel = base_sel;
	end

	// Settings and access payload, loaded whenever idle
	always_ff @(posedge i_clk)
	begin
		if (!o_busy)
		begin
			o_inc <= i_inc;
			o_size <= i_size;
			r_addr <= i_addr;
			stb_size <= o_first_bytes;
			o_rd_sel <= first_sel;
			base_sel <= unit_sel(i_size, i_addr[BUS_LSB-1:0]);
		end
		else if (taken)
		begin
			stb_size <= next_size;
			o_rd_sel <= next_sel;
			base_sel <= next_sel;
			if (o_inc)
				r_addr <= r_addr + {{(ADDRESS_WIDTH-3){1'b0}}, stb_size};
		end
	end

	////////////////////////////////////////
	// Bus cycle control
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_busy <= 1'b0;
			o_err <= 1'b0;
			o_rd_cyc <= 1'b0;
			o_rd_stb <= 1'b0;
			stb_len <= '0;
		end
		else if (o_rd_cyc && i_rd_err)
		begin
			// Abort, error flag holds until the next start
			o_busy <= 1'b0;
			o_err <= 1'b1;
			o_rd_cyc <= 1'b0;
			o_rd_stb <= 1'b0;
			stb_len <= '0;
		end
		else if (!o_busy)
		begin
			o_busy <= i_request;
			o_rd_cyc <= i_request;
			o_rd_stb <= i_request;
			stb_len <= i_transferlen;
			if (i_request)
				o_err <= 1'b0;
		end
		else
		begin
			// Strobe stays up while bytes remain to be requested
			if (taken)
			begin
				if (stb_len <= stb_size_ext)
				begin
					stb_len <= '0;
					o_rd_stb <= 1'b0;
				end
				else
					stb_len <= stb_rem;
			end
			// Close once the final read is coming back
			if (!o_rd_stb && outstanding == (LGLENGTH+1)'(i_rd_ack))
				o_rd_cyc <= 1'b0;
			if (i_done)
				o_busy <= 1'b0;
		end
	end

	// Reads in flight
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !o_rd_cyc || i_rd_err)
			outstanding <= '0;
		else
		begin
			case ({taken, i_rd_ack})
			2'b10: outstanding <= outstanding + 1'b1;
			2'b01: outstanding <= outstanding - 1'b1;
			default: outstanding <= outstanding;
			endcase
		end
	end

	// Strobe only inside a cycle, never with an empty select
	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		o_rd_stb |-> o_rd_cyc);
	a_sel_nonzero: assert property (@(posedge i_clk) disable iff (i_reset)
		o_rd_stb |-> (o_rd_sel != '0));

endmodule

// ==== verilog/dma_xfer_pkg.sv ====
// Transfer-side definitions of the DMA reader.
// Holds the transfer size encoding, the byte count types and the
// helpers that size the first access and build its select mask.
// Used by the request, return and stream stages and the top level.

package dma_xfer_pkg;
	import wb_bus_pkg::*;

	// Access size, code 1 behaves as a full word
	typedef enum logic [1:0] {
		XS_WORD = 2'd0,
		XS_HALF = 2'd2,
		XS_BYTE = 2'd3
	} xfer_size_e;

	// Bytes in one beat or access, 0 to 4
	typedef logic [2:0] beat_bytes_t;
	// Bytes held in the packer, 0 to 7
	typedef logic [2:0] fill_t;

	// Bytes from the lane to the end of the aligned unit, cut to the
	// length left; len_cap is that length already saturated at 4.
	// At lane 0 this is simply the size of one full chunk
	function automatic beat_bytes_t first_chunk_bytes(input xfer_size_e size,
			input byte_lane_t lane, input beat_bytes_t len_cap);
		beat_bytes_t n;
		case (size)
		XS_BYTE: n = 3'd1;
		XS_HALF: n = 3'd2 - {2'b00, lane[0]};
		default: n = 3'(BUS_BYTES) - {1'b0, lane};
		endcase
		if (n > len_cap)
			n = len_cap;
		return n;
	endfunction

	// Select mask of the whole aligned unit that holds the lane
	function automatic bus_sel_t unit_sel(input xfer_size_e size, input byte_lane_t lane);
		bus_sel_t sel;
		case (size)
		XS_BYTE: sel = 4'b1000 >> lane;
		XS_HALF: sel = lane[1] ? 4'b0011 : 4'b1100;
		default: sel = 4'b1111;
		endcase
		return sel;
	endfunction

endpackage

// ==== verilog/wb_bus_pkg.sv ====
// Widths and vector types of the 32-bit Wishbone read port.
// Imported by the DMA reader modules and by the transfer package.
// Byte lane 0 is the most significant byte of a bus word, so
// the byte at the lowest address sits in bits 31..24.

package wb_bus_pkg;

	////////////////////////////////////////
	// Bus geometry
	////////////////////////////////////////

	// Bytes per bus word
	localparam int BUS_BYTES = 4;
	// Address bits that pick a byte within a word
	localparam int BUS_LSB = 2;

	////////////////////////////////////////
	// Vector types
	////////////////////////////////////////

	// One bus word, read data
	typedef logic [8*BUS_BYTES-1:0] bus_data_t;
	// One select bit per byte lane, lane 0 in the MSB
	typedef logic [BUS_BYTES-1:0] bus_sel_t;
	// Byte offset within a bus word
	typedef logic [BUS_LSB-1:0] byte_lane_t;

endpackage
